// File: design/awe_rowbuffers.sv
`include "quad_config.svh"

module awe_rowbuffers
    import quad_pkg::*;
(
    input  logic                  clk_500MHz,
    input  logic                  rst,
    input  logic                  shift,
    input  logic                  emit,
    input  logic [`COL_WIDTH-1:0] input_col,
    input  pixel_t                ce0_pixel,
    input  pixel_t                ce1_pixel,
    output sum_t                  ce0_sum,
    output sum_t                  ce1_sum,
    output logic                  sum_valid
);

    localparam int NUM_CE = `NUM_CE_PER_AWE;

    pixel_t lane_pixel [NUM_CE];
    sum_t   lane_sum   [NUM_CE];

    assign lane_pixel[0] = ce0_pixel;
    assign lane_pixel[1] = ce1_pixel;
    assign ce0_sum       = lane_sum[0];
    assign ce1_sum       = lane_sum[1];

    ////////////////////////////////////////////////////////////
    // Per-lane line memories
    ////////////////////////////////////////////////////////////
    genvar g;
    generate
        for (g = 0; g < NUM_CE; g = g + 1) begin : g_lane
            // Previous row and the row before it
            pixel_t row_m1 [`MAX_COLS];
            pixel_t row_m2 [`MAX_COLS];
            pixel_t above1;
            pixel_t above2;
            sum_t   col_sum;

            assign above1 = row_m1[input_col];
            assign above2 = row_m2[input_col];

            // Zero extension keeps the three-term sum exact
            assign col_sum = sum_t'(lane_pixel[g]) + sum_t'(above1) + sum_t'(above2);

            always_ff @(posedge clk_500MHz) begin
                if (shift) begin
                    // Older row takes over the newer one
                    row_m2[input_col] <= above1;
                    row_m1[input_col] <= lane_pixel[g];
                end
            end

            always_ff @(posedge clk_500MHz) begin
                if (shift) begin
                    lane_sum[g] <= col_sum;
                end
            end
        end
    endgenerate

    ////////////////////////////////////////////////////////////
    // Valid pipeline
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk_500MHz) begin
        if (rst) begin
            sum_valid <= 1'b0;
        end else begin
            sum_valid <= emit;
        end
    end

    // Column index from the controller must fit the line memory
    assert property (@(posedge clk_500MHz) disable iff (rst)
        shift |-> (int'(input_col) < `MAX_COLS))
        else $error("awe_rowbuffers column out of range");

endmodule

// File: design/cnn_layer_accel_quad.sv
`include "quad_config.svh"

module cnn_layer_accel_quad
    import quad_pkg::*;
(
    input  logic         clk_500MHz,
    input  logic         rst,
    input  logic         config_wren,
    input  logic [31:0]  config_data,
    input  logic         start,
    output logic         busy,
    input  logic         from_network_valid,
    input  lane_pixels_t from_network_payload,
    output logic         from_network_credit,
    output logic         to_network_valid,
    output lane_sums_t   to_network_payload,
    input  logic         to_network_credit
);

    localparam int OUT_CNT_W = $clog2(`OUT_DEPTH + 1);

    lane_pixels_t          pfb_data;
    logic                  pfb_empty;
    logic                  pfb_rden;
    lane_sums_t            lane_sums;
    logic [`NUM_AWE-1:0]   awe_sum_valid;
    logic [OUT_CNT_W-1:0]  out_free;
    logic                  out_empty;
    logic                  out_rden;
    logic [`COL_WIDTH-1:0] input_col;
    logic                  emit;

    assign from_network_credit = pfb_rden;
    assign to_network_valid    = out_rden;

    ////////////////////////////////////////////////////////////
    // Prefetch buffer and output queue
    ////////////////////////////////////////////////////////////
    credit_fifo #(
        .item_t ( lane_pixels_t ),
        .DEPTH  ( `PFB_DEPTH    )
    ) i0_prefetch_buffer (
        .clk_500MHz ( clk_500MHz           ),
        .rst        ( rst                  ),
        .push       ( from_network_valid   ),
        .push_data  ( from_network_payload ),
        .pop        ( pfb_rden             ),
        .pop_data   ( pfb_data             ),
        .empty      ( pfb_empty            ),
        .free_count (                      )
    );

    // All AWE blocks share one timing so AWE 0 qualifies the write
    credit_fifo #(
        .item_t ( lane_sums_t ),
        .DEPTH  ( `OUT_DEPTH  )
    ) i0_output_queue (
        .clk_500MHz ( clk_500MHz         ),
        .rst        ( rst                ),
        .push       ( awe_sum_valid[0]   ),
        .push_data  ( lane_sums          ),
        .pop        ( out_rden           ),
        .pop_data   ( to_network_payload ),
        .empty      ( out_empty          ),
        .free_count ( out_free           )
    );

    ////////////////////////////////////////////////////////////
    // Controller and row buffers
    ////////////////////////////////////////////////////////////
    quad_bram_ctrl i0_quad_bram_ctrl (
        .clk_500MHz        ( clk_500MHz        ),
        .rst               ( rst               ),
        .config_wren       ( config_wren       ),
        .config_data       ( config_data       ),
        .start             ( start             ),
        .busy              ( busy              ),
        .pfb_empty         ( pfb_empty         ),
        .pfb_rden          ( pfb_rden          ),
        .out_free          ( out_free          ),
        .out_empty         ( out_empty         ),
        .out_rden          ( out_rden          ),
        .to_network_credit ( to_network_credit ),
        .input_col         ( input_col         ),
        .emit              ( emit              )
    );

    genvar i;
    generate
        for (i = 0; i < `NUM_AWE; i = i + 1) begin : g_awe
            awe_rowbuffers i0_awe_rowbuffers (
                .clk_500MHz ( clk_500MHz                           ),
                .rst        ( rst                                  ),
                .shift      ( pfb_rden                             ),
                .emit       ( emit                                 ),
                .input_col  ( input_col                            ),
                .ce0_pixel  ( pfb_data[`NUM_CE_PER_AWE * i]        ),
                .ce1_pixel  ( pfb_data[`NUM_CE_PER_AWE * i + 1]    ),
                .ce0_sum    ( lane_sums[`NUM_CE_PER_AWE * i]       ),
                .ce1_sum    ( lane_sums[`NUM_CE_PER_AWE * i + 1]   ),
                .sum_valid  ( awe_sum_valid[i]                     )
            );
        end
    endgenerate

endmodule

// File: design/credit_fifo.sv
module credit_fifo #(
    parameter type item_t = logic [7:0],
    parameter int  DEPTH  = 16,
    localparam int CNT_W  = $clog2(DEPTH + 1),
    localparam int PTR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
    input  logic             clk_500MHz,
    input  logic             rst,
    input  logic             push,
    input  item_t            push_data,
    input  logic             pop,
    output item_t            pop_data,
    output logic             empty,
    output logic [CNT_W-1:0] free_count
);

    ////////////////////////////////////////////////////////////
    // Storage and pointers
    ////////////////////////////////////////////////////////////
    item_t            mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;

    assign empty      = (count == '0);
    assign full       = (count == CNT_W'(DEPTH));
    assign free_count = CNT_W'(DEPTH) - count;

    // Head word is always visible
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk_500MHz) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk_500MHz) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////
    // The writer's credit accounting must keep it out of a full buffer
    assert property (@(posedge clk_500MHz) disable iff (rst) push |-> !full)
        else $error("credit_fifo push while full");

    assert property (@(posedge clk_500MHz) disable iff (rst) pop |-> !empty)
        else $error("credit_fifo pop while empty");

endmodule

// File: design/quad_bram_ctrl.sv
`include "quad_config.svh"

module quad_bram_ctrl
    import quad_pkg::*;
#(
    localparam int OUT_CNT_W    = $clog2(`OUT_DEPTH + 1),
    localparam int CREDIT_WIDTH = 16
) (
    input  logic                  clk_500MHz,
    input  logic                  rst,
    input  logic                  config_wren,
    input  logic [31:0]           config_data,
    input  logic                  start,
    output logic                  busy,
    input  logic                  pfb_empty,
    output logic                  pfb_rden,
    input  logic [OUT_CNT_W-1:0]  out_free,
    input  logic                  out_empty,
    output logic                  out_rden,
    input  logic                  to_network_credit,
    output logic [`COL_WIDTH-1:0] input_col,
    output logic                  emit
);

    ////////////////////////////////////////////////////////////
    // Configuration registers
    ////////////////////////////////////////////////////////////
    logic [15:0] num_cols_cfg;
    logic [15:0] num_rows_cfg;

    always_ff @(posedge clk_500MHz) begin
        if (rst) begin
            num_cols_cfg <= '0;
            num_rows_cfg <= '0;
        end else if (config_wren) begin
            num_cols_cfg <= config_data[15:0];
            num_rows_cfg <= config_data[31:16];
        end
    end

    ////////////////////////////////////////////////////////////
    // State machine and raster counters
    ////////////////////////////////////////////////////////////
    quad_state_t state;
    quad_state_t state_next;
    logic [15:0] input_row;
    logic        last_col;
    logic        last_row;

    assign last_col = (16'(input_col) == num_cols_cfg - 16'd1);
    assign last_row = (input_row == num_rows_cfg - 16'd1);
    assign busy     = (state != ST_IDLE);

    // Room for this word plus the one still in the sum register
    assign pfb_rden = (state == ST_AWE_CE_ACTIVE) && !pfb_empty
                      && (out_free >= OUT_CNT_W'(2));

    // First two rows only prime the line memories
    assign emit = pfb_rden && (input_row >= 16'd2);

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (start) begin
                    state_next = ST_AWE_CE_PRIM_BUFFER;
                end
            end
            ST_AWE_CE_PRIM_BUFFER: begin
                state_next = ST_WAIT_PFB_LOAD;
            end
            ST_WAIT_PFB_LOAD: begin
                if (!pfb_empty) begin
                    state_next = ST_AWE_CE_ACTIVE;
                end
            end
            ST_AWE_CE_ACTIVE: begin
                if (pfb_rden && last_col && last_row) begin
                    state_next = ST_IDLE;
                end
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_500MHz) begin
        if (rst) begin
            state     <= ST_IDLE;
            input_row <= '0;
            input_col <= '0;
        end else begin
            state <= state_next;
            if (state == ST_AWE_CE_PRIM_BUFFER) begin
                input_row <= '0;
                input_col <= '0;
            end else if (pfb_rden) begin
                if (last_col) begin
                    input_col <= '0;
                    input_row <= input_row + 16'd1;
                end else begin
                    input_col <= input_col + 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Output credits
    ////////////////////////////////////////////////////////////
    logic [CREDIT_WIDTH-1:0] credit_count;

    assign out_rden = !out_empty && (credit_count != '0);

    always_ff @(posedge clk_500MHz) begin
        if (rst) begin
            credit_count <= '0;
        end else begin
            case ({to_network_credit, out_rden})
                2'b10:   credit_count <= credit_count + 1'b1;
                2'b01:   credit_count <= credit_count - 1'b1;
                default: credit_count <= credit_count;
            endcase
        end
    end

    // A grant into a saturated counter would be lost
    assert property (@(posedge clk_500MHz) disable iff (rst)
        (to_network_credit && !out_rden) |-> (credit_count != '1))
        else $error("quad_bram_ctrl output credit counter overflow");

endmodule

// File: design/quad_config.svh
`ifndef QUAD_CONFIG_SVH
`define QUAD_CONFIG_SVH

////////////////////////////////////////////////////////////
// Lane organization
////////////////////////////////////////////////////////////
`define NUM_AWE         2
`define NUM_CE_PER_AWE  2
`define NUM_LANES       (`NUM_AWE * `NUM_CE_PER_AWE)

////////////////////////////////////////////////////////////
// Datapath widths
////////////////////////////////////////////////////////////
`define PIXEL_WIDTH     16
// Two guard bits cover the sum of three pixels
`define SUM_WIDTH       18

////////////////////////////////////////////////////////////
// Memory and buffer sizing
////////////////////////////////////////////////////////////
`define MAX_COLS        64
`define COL_WIDTH       6
`define PFB_DEPTH       16
`define OUT_DEPTH       8

`endif

// File: design/quad_pkg.sv
`include "quad_config.svh"

package quad_pkg;

    ////////////////////////////////////////////////////////////
    // Pixel and sum words
    ////////////////////////////////////////////////////////////
    typedef logic [`PIXEL_WIDTH-1:0] pixel_t;
    typedef logic [`SUM_WIDTH-1:0]   sum_t;

    // Lane 0 sits in the low bits
    typedef pixel_t [`NUM_LANES-1:0] lane_pixels_t;
    typedef sum_t   [`NUM_LANES-1:0] lane_sums_t;

    ////////////////////////////////////////////////////////////
    // Controller states
    ////////////////////////////////////////////////////////////
    // One-hot encoding
    typedef enum logic [3:0] {
        ST_IDLE               = 4'b0001,
        ST_AWE_CE_PRIM_BUFFER = 4'b0010,
        ST_WAIT_PFB_LOAD      = 4'b0100,
        ST_AWE_CE_ACTIVE      = 4'b1000
    } quad_state_t;

endpackage

// File: run.sh
#!/bin/sh
# Compile and run the quad testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_quad -f sources.f -o tb_quad

./obj_dir/tb_quad | tee sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

// File: sources.f
+incdir+design
design/quad_pkg.sv
design/credit_fifo.sv
design/awe_rowbuffers.sv
design/quad_bram_ctrl.sv
design/cnn_layer_accel_quad.sv
verif/tb_quad.sv

// File: verif/quad_cases.txt
# C width height | P lane0 lane1 lane2 lane3 pixels hex | R hold_credits_at_start
# E lane0 lane1 lane2 lane3 expected 3x1 column sums hex, raster order from row 2
C 5 4
P 0000 0100 0200 0300
P 0001 0101 0201 0301
P 0002 0102 0202 0302
P 0003 0103 0203 0303
P 0004 0104 0204 0304
P 0010 0110 0210 0310
P 0011 0111 0211 0311
P 0012 0112 0212 0312
P 0013 0113 0213 0313
P 0014 0114 0214 0314
P 0020 0120 0220 0320
P 0021 0121 0221 0321
P 0022 0122 0222 0322
P 0023 0123 0223 0323
P 0024 0124 0224 0324
P 0030 0130 0230 0330
P 0031 0131 0231 0331
P 0032 0132 0232 0332
P 0033 0133 0233 0333
P 0034 0134 0234 0334
E 00030 00330 00630 00930
E 00033 00333 00633 00933
E 00036 00336 00636 00936
E 00039 00339 00639 00939
E 0003c 0033c 0063c 0093c
E 00060 00360 00660 00960
E 00063 00363 00663 00963
E 00066 00366 00666 00966
E 00069 00369 00669 00969
E 0006c 0036c 0066c 0096c
R 1
C 6 3
P ff00 ff40 ff80 ffc0
P ff01 ff41 ff81 ffc1
P ff02 ff42 ff82 ffc2
P ff03 ff43 ff83 ffc3
P ff04 ff44 ff84 ffc4
P ff05 ff45 ff85 ffc5
P ff10 ff50 ff90 ffd0
P ff11 ff51 ff91 ffd1
P ff12 ff52 ff92 ffd2
P ff13 ff53 ff93 ffd3
P ff14 ff54 ff94 ffd4
P ff15 ff55 ff95 ffd5
P ff20 ff60 ffa0 ffe0
P ff21 ff61 ffa1 ffe1
P ff22 ff62 ffa2 ffe2
P ff23 ff63 ffa3 ffe3
P ff24 ff64 ffa4 ffe4
P ff25 ff65 ffa5 ffe5
E 2fd30 2fdf0 2feb0 2ff70
E 2fd33 2fdf3 2feb3 2ff73
E 2fd36 2fdf6 2feb6 2ff76
E 2fd39 2fdf9 2feb9 2ff79
E 2fd3c 2fdfc 2febc 2ff7c
E 2fd3f 2fdff 2febf 2ff7f
R 0

// File: verif/tb_quad.sv
`include "quad_config.svh"

module tb_quad
    import quad_pkg::*;
();

    localparam int PFB_CREDITS   = `PFB_DEPTH;
    localparam int HOLD_CYCLES   = 60;
    localparam int IMAGE_TIMEOUT = 4000;

    logic         clk_500MHz;
    logic         rst;
    logic         config_wren;
    logic [31:0]  config_data;
    logic         start;
    logic         busy;
    logic         from_network_valid;
    lane_pixels_t from_network_payload;
    logic         from_network_credit;
    logic         to_network_valid;
    lane_sums_t   to_network_payload;
    logic         to_network_credit;

    // Pixel words to send and sums still awaited
    lane_pixels_t pix_q [$];
    lane_sums_t   exp_q [$];

    int     in_credits;
    int     words_sent;
    int     credits_returned;
    int     words_recv;
    int     credits_granted;
    int     words_out_total;
    int     images_run;
    logic   feeding;
    logic   hold_credits;
    integer seed;

    cnn_layer_accel_quad dut (
        .clk_500MHz           ( clk_500MHz           ),
        .rst                  ( rst                  ),
        .config_wren          ( config_wren          ),
        .config_data          ( config_data          ),
        .start                ( start                ),
        .busy                 ( busy                 ),
        .from_network_valid   ( from_network_valid   ),
        .from_network_payload ( from_network_payload ),
        .from_network_credit  ( from_network_credit  ),
        .to_network_valid     ( to_network_valid     ),
        .to_network_payload   ( to_network_payload   ),
        .to_network_credit    ( to_network_credit    )
    );

    initial begin
        clk_500MHz = 1'b0;
        forever #50 clk_500MHz = ~clk_500MHz;
    end

    ////////////////////////////////////////////////////////////
    // Checking helpers
    ////////////////////////////////////////////////////////////
    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAILED time=%0t signal=%s expected=0x%0h actual=0x%0h",
                     $time, name, expected, actual);
            $display("TESTBENCH FAILED");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic fail_now(input string reason);
        $display("ERROR time=%0t %s", $time, reason);
        $display("TESTBENCH FAILED");
        $fatal(1, "%s", reason);
    endtask

    task automatic compare_sums(input lane_sums_t expected, input lane_sums_t actual);
        int lane;
        for (lane = 0; lane < `NUM_LANES; lane++) begin
            check_value($sformatf("to_network_payload[%0d]", lane),
                        32'(expected[lane]), 32'(actual[lane]));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Upstream sender and downstream credit granter
    ////////////////////////////////////////////////////////////
    initial begin
        from_network_valid   <= 1'b0;
        from_network_payload <= '0;
        forever begin
            @(posedge clk_500MHz);
            // Only send while a prefetch buffer credit is held
            if (feeding && in_credits > 0 && pix_q.size() > 0) begin
                from_network_valid   <= 1'b1;
                from_network_payload <= pix_q.pop_front();
                in_credits = in_credits - 1;
                words_sent = words_sent + 1;
            end else begin
                from_network_valid <= 1'b0;
            end
        end
    end

    initial begin
        seed = 32'hcdee;
        to_network_credit <= 1'b0;
        forever begin
            @(posedge clk_500MHz);
            // Grants land in about three cycles out of four
            if (!rst && !hold_credits && ($random(seed) & 3) != 0) begin
                to_network_credit <= 1'b1;
            end else begin
                to_network_credit <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Output monitor and scoreboard
    ////////////////////////////////////////////////////////////
    initial begin
        forever begin
            @(negedge clk_500MHz);
            if (!rst) begin
                if (from_network_credit) begin
                    in_credits       = in_credits + 1;
                    credits_returned = credits_returned + 1;
                end
                if (credits_returned > words_sent) begin
                    fail_now("quad returned more prefetch buffer credits than words sent");
                end
                if (to_network_valid) begin
                    words_out_total = words_out_total + 1;
                    if (words_out_total > credits_granted) begin
                        fail_now("quad sent more words than output credits granted");
                    end
                    if (exp_q.size() == 0) begin
                        fail_now("output word arrived with no expected word pending");
                    end
                    compare_sums(exp_q.pop_front(), to_network_payload);
                    words_recv = words_recv + 1;
                end
                // A grant can be spent from the next cycle on
                if (to_network_credit) begin
                    credits_granted = credits_granted + 1;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // One image from configuration to last output word
    ////////////////////////////////////////////////////////////
    task automatic run_image(input int width, input int height, input logic hold);
        int expected_words;
        int cycles;
        expected_words = (height - 2) * width;
        check_value("expected record count", expected_words, exp_q.size());
        check_value("pixel record count", width * height, pix_q.size());
        @(posedge clk_500MHz);
        config_wren <= 1'b1;
        config_data <= {height[15:0], width[15:0]};
        @(posedge clk_500MHz);
        config_wren <= 1'b0;
        start       <= 1'b1;
        @(posedge clk_500MHz);
        start <= 1'b0;
        @(negedge clk_500MHz);
        check_value("busy", 32'd1, 32'(busy));
        words_sent       = 0;
        credits_returned = 0;
        words_recv       = 0;
        hold_credits     = hold;
        feeding          = 1'b1;
        if (hold) begin
            // Output queue fills and popping stalls
            repeat (HOLD_CYCLES) @(posedge clk_500MHz);
            check_value("words sent during credit hold", 32'd0, words_recv);
            @(negedge clk_500MHz);
            hold_credits = 1'b0;
        end
        cycles = 0;
        while ((exp_q.size() > 0 || busy) && cycles < IMAGE_TIMEOUT) begin
            @(posedge clk_500MHz);
            cycles = cycles + 1;
        end
        if (exp_q.size() > 0 || busy) begin
            fail_now("timeout waiting for the image to finish");
        end
        @(negedge clk_500MHz);
        check_value("words received", expected_words, words_recv);
        check_value("words sent upstream", width * height, words_sent);
        check_value("credits returned", words_sent, credits_returned);
        check_value("busy", 32'd0, 32'(busy));
        feeding    = 1'b0;
        images_run = images_run + 1;
    endtask

    initial begin
        int               fd;
        int               code;
        int               width;
        int               height;
        int               hold;
        int               lane;
        logic [7:0]       tag;
        logic [31:0]      vals [`NUM_LANES];
        logic [8*128-1:0] rest;
        lane_pixels_t     pix_word;
        lane_sums_t       sum_word;

        rst         <= 1'b1;
        config_wren <= 1'b0;
        config_data <= '0;
        start       <= 1'b0;
        in_credits       = PFB_CREDITS;
        words_sent       = 0;
        credits_returned = 0;
        words_recv       = 0;
        credits_granted  = 0;
        words_out_total  = 0;
        images_run       = 0;
        feeding          = 1'b0;
        hold_credits     = 1'b1;
        width            = 0;
        height           = 0;

        repeat (4) @(posedge clk_500MHz);
        rst <= 1'b0;
        @(negedge clk_500MHz);
        check_value("to_network_valid", 32'd0, 32'(to_network_valid));
        check_value("from_network_credit", 32'd0, 32'(from_network_credit));
        check_value("busy", 32'd0, 32'(busy));

        fd = $fopen("verif/quad_cases.txt", "r");
        if (fd == 0) begin
            fail_now("cannot open verif/quad_cases.txt");
        end
        code = $fscanf(fd, "%s", tag);
        while (code == 1) begin
            if (tag == "#") begin
                code = $fgets(rest, fd);
            end else if (tag == "C") begin
                code = $fscanf(fd, "%d %d", width, height);
                if (code != 2) begin
                    fail_now("malformed configuration record in case file");
                end
            end else if (tag == "P" || tag == "E") begin
                code = $fscanf(fd, "%h %h %h %h", vals[0], vals[1], vals[2], vals[3]);
                if (code != `NUM_LANES) begin
                    fail_now("malformed lane record in case file");
                end
                for (lane = 0; lane < `NUM_LANES; lane++) begin
                    pix_word[lane] = vals[lane][`PIXEL_WIDTH-1:0];
                    sum_word[lane] = vals[lane][`SUM_WIDTH-1:0];
                end
                if (tag == "P") begin
                    pix_q.push_back(pix_word);
                end else begin
                    exp_q.push_back(sum_word);
                end
            end else if (tag == "R") begin
                code = $fscanf(fd, "%d", hold);
                if (code != 1) begin
                    fail_now("malformed run record in case file");
                end
                run_image(width, height, hold != 0);
            end else begin
                fail_now("unknown record tag in case file");
            end
            code = $fscanf(fd, "%s", tag);
        end
        $fclose(fd);
        check_value("images run", 32'd2, images_run);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule
